/* verilog/tia_params.svh */
/*
 * tia video constants
 * bus widths, line geometry and horizontal lfsr decode codes
 */
`ifndef TIA_PARAMS_SVH
`define TIA_PARAMS_SVH

// cpu bus
`define TIA_DATA_W 8
`define TIA_ADDR_W 6

// line geometry, in color clocks
`define TIA_PF_BITS 20
`define TIA_HCNT_W 6
`define TIA_CC_PER_HCNT 4
`define TIA_CC_PER_LINE 228
`define TIA_HBLANK_CC 68
`define TIA_HSYNC_CC 16
`define TIA_LUMA_COLOR_W 7

// lfsr states, decoded one step ahead of the hp2 that acts on them
`define TIA_HC_END 6'b010100
`define TIA_HC_SHS 6'b111000
`define TIA_HC_RHS 6'b101111
`define TIA_HC_RHB 6'b011100
`define TIA_HC_CNT 6'b101100
`define TIA_HC_ERR 6'b111111

`endif

/* verilog/tia_pkg.sv */
/*
 * shared tia video types
 * write register map, horizontal events, color and playfield formats
 */
`include "tia_params.svh"

package tia_pkg;

	// kept write addresses only
	typedef enum logic [`TIA_ADDR_W-1:0] {
		VSYNC  = 6'h00,
		VBLANK = 6'h01,
		WSYNC  = 6'h02,
		RSYNC  = 6'h03,
		COLUPF = 6'h08,
		COLUBK = 6'h09,
		CTRLPF = 6'h0A,
		PF0    = 6'h0D,
		PF1    = 6'h0E,
		PF2    = 6'h0F
	} write_reg_e;

	// horizontal lfsr events
	typedef enum logic [2:0] {
		H_NONE,
		H_END,
		H_SET_HSYNC,
		H_RST_HSYNC,
		H_RST_HBLANK,
		H_CENTER,
		H_ERR
	} hdecode_e;

	// register bits 7:1, hue on top
	typedef struct packed {
		logic [3:0] color;
		logic [2:0] luma;
	} lumcol_t;

	// bit i is the i-th playfield bit drawn on the left half
	typedef logic [`TIA_PF_BITS-1:0] pf_bits_t;

endpackage

/* verilog/hline_if.sv */
/*
 * horizontal line bundle
 * phase strobes and line events from timing to pixel path
 */
`timescale 1ns/10ps

interface hline_if;

	// phase strobes, one clk each
	logic hp1;
	logic hp2;
	// line events, all pulses except hblank
	logic cnt;
	logic rhb;
	logic hblank;
	logic line_end;

	modport phase (output hp1, hp2);
	modport horiz (input hp1, hp2, output cnt, rhb, hblank, line_end);
	modport pixel (input hp2, cnt, rhb, hblank);
	modport regs (input line_end);

endinterface

/* verilog/phase_clock_gen.sv */
/*
 * horizontal phase clock generator
 * hp1 and hp2 strobes from the color clock, realigned by rsync
 */
`timescale 1ns/10ps
`include "tia_params.svh"

module phase_clock_gen (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic rsync,
	hline_if.phase line
);

	localparam int DIV_W = $clog2(`TIA_CC_PER_HCNT);
	localparam logic [DIV_W-1:0] HP2_PHASE = DIV_W'(`TIA_CC_PER_HCNT / 2);

	logic [DIV_W-1:0] div;
	logic realign_pend;
	logic realign;

	// rsync seen now or parked since the last ce
	assign realign = rsync | realign_pend;

	// realigning ce counts as phase 0
	assign line.hp1 = ce & (realign | (div == '0));
	assign line.hp2 = ce & ~realign & (div == HP2_PHASE);

	always_ff @(posedge clk) begin
		if (rst) begin
			div <= '0;
			realign_pend <= 1'b0;
		end else if (ce) begin
			// hp1 issued here, so carry on from phase 1
			div <= realign ? DIV_W'(1) : div + DIV_W'(1);
			realign_pend <= 1'b0;
		end else if (rsync) begin
			realign_pend <= 1'b1;
		end
	end

	// the two phases stay apart through realignment
	a_phase_excl: assert property (@(posedge clk) disable iff (rst)
		!(line.hp1 && line.hp2));

endmodule

/* verilog/horiz_sync_gen.sv */
/*
 * horizontal sync counter
 * 6-bit lfsr stepped on hp2, decoded into sync, blank and center events
 */
`timescale 1ns/10ps
`include "tia_params.svh"

module horiz_sync_gen (
	input  logic clk,
	input  logic rst,
	input  logic rsync,
	hline_if.horiz line,
	output logic hsync
);

	logic [`TIA_HCNT_W-1:0] lfsr;
	tia_pkg::hdecode_e hdec;
	logic restart_q;
	logic rsync_pend;
	logic center;
	logic end_or_err;

	// lfsr state to event
	always_comb begin
		case (lfsr)
			`TIA_HC_END: hdec = tia_pkg::H_END;
			`TIA_HC_SHS: hdec = tia_pkg::H_SET_HSYNC;
			`TIA_HC_RHS: hdec = tia_pkg::H_RST_HSYNC;
			`TIA_HC_RHB: hdec = tia_pkg::H_RST_HBLANK;
			`TIA_HC_CNT: hdec = tia_pkg::H_CENTER;
			`TIA_HC_ERR: hdec = tia_pkg::H_ERR;
			default:     hdec = tia_pkg::H_NONE;
		endcase
	end

	assign end_or_err = (hdec == tia_pkg::H_END) || (hdec == tia_pkg::H_ERR);

	// pulses share the hp2 cycle that acts on them
	assign line.line_end = line.hp2 & restart_q;
	assign line.rhb = line.hp2 & ~restart_q & (hdec == tia_pkg::H_RST_HBLANK);
	assign line.cnt = line.hp2 & ~restart_q & (hdec == tia_pkg::H_CENTER);

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr <= '0;
			restart_q <= 1'b0;
			rsync_pend <= 1'b0;
			hsync <= 1'b0;
			line.hblank <= 1'b0;
			center <= 1'b0;
		end else begin
			// hold rsync until the realigned hp1
			if (rsync)
				rsync_pend <= 1'b1;

			// restart decided half a step ahead
			if (line.hp1) begin
				restart_q <= end_or_err | rsync | rsync_pend;
				rsync_pend <= 1'b0;
			end

			if (line.hp2) begin
				if (restart_q) begin
					lfsr <= '0;
					restart_q <= 1'b0;
					line.hblank <= 1'b1;
					hsync <= 1'b0;
					center <= 1'b0;
				end else begin
					// xnor feedback, locks up only at all ones
					lfsr <= {lfsr[1] ~^ lfsr[0], lfsr[`TIA_HCNT_W-1:1]};
					case (hdec)
						tia_pkg::H_SET_HSYNC:  hsync <= 1'b1;
						tia_pkg::H_RST_HSYNC:  hsync <= 1'b0;
						tia_pkg::H_RST_HBLANK: line.hblank <= 1'b0;
						tia_pkg::H_CENTER:     center <= 1'b1;
						default: ;
					endcase
				end
			end
		end
	end

	// lfsr never reaches the lock-up state from a clean start
	a_no_err: assert property (@(posedge clk) disable iff (rst)
		hdec != tia_pkg::H_ERR);

	// right half of the line is always visible
	a_center_vis: assert property (@(posedge clk) disable iff (rst)
		!(center && line.hblank));

endmodule

/* verilog/tia_reg_file.sv */
/*
 * tia write registers
 * bus write decode, stored video registers, wsync and rsync strobes
 */
`timescale 1ns/10ps
`include "tia_params.svh"

module tia_reg_file (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cs_n,
	input  logic                   rw_n,
	input  logic [`TIA_ADDR_W-1:0] addr,
	input  logic [`TIA_DATA_W-1:0] d_in,
	hline_if.regs                  line,
	output logic                   rsync,
	output logic                   rdy,
	output logic                   vsync,
	output logic                   vblank,
	output logic                   reflect,
	output tia_pkg::pf_bits_t      pf_bits,
	output tia_pkg::lumcol_t       colupf,
	output tia_pkg::lumcol_t       colubk
);

	tia_pkg::write_reg_e addr_e;
	logic wr;
	logic [3:0] pf0;
	logic [7:0] pf1;
	logic [7:0] pf2;

	assign addr_e = tia_pkg::write_reg_e'(addr);
	assign wr = ~cs_n & ~rw_n;

	always_ff @(posedge clk) begin
		if (rst) begin
			vsync <= 1'b0;
			vblank <= 1'b0;
			reflect <= 1'b0;
			pf0 <= '0;
			pf1 <= '0;
			pf2 <= '0;
			colupf <= '0;
			colubk <= '0;
		end else if (wr) begin
			case (addr_e)
				tia_pkg::VSYNC:  vsync <= d_in[1];
				tia_pkg::VBLANK: vblank <= d_in[1];
				tia_pkg::CTRLPF: reflect <= d_in[0];
				// pf0 keeps only its top nibble
				tia_pkg::PF0:    pf0 <= d_in[7:4];
				tia_pkg::PF1:    pf1 <= d_in;
				tia_pkg::PF2:    pf2 <= d_in;
				tia_pkg::COLUPF: colupf <= d_in[`TIA_DATA_W-1 -: `TIA_LUMA_COLOR_W];
				tia_pkg::COLUBK: colubk <= d_in[`TIA_DATA_W-1 -: `TIA_LUMA_COLOR_W];
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// strobes
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			rsync <= 1'b0;
			rdy <= 1'b1;
		end else begin
			rsync <= wr && (addr_e == tia_pkg::RSYNC);
			// a fresh wsync outranks the line end
			if (wr && (addr_e == tia_pkg::WSYNC))
				rdy <= 1'b0;
			else if (line.line_end)
				rdy <= 1'b1;
		end
	end

	// draw order: pf0 4..7, pf1 7..0, pf2 0..7
	always_comb begin
		for (int i = 0; i < 4; i++)
			pf_bits[i] = pf0[i];
		for (int i = 0; i < 8; i++) begin
			pf_bits[4 + i] = pf1[7 - i];
			pf_bits[12 + i] = pf2[i];
		end
	end

	// cpu is halted from the cycle after a wsync write
	a_wsync_halt: assert property (@(posedge clk) disable iff (rst)
		(wr && addr_e == tia_pkg::WSYNC) |=> !rdy);

endmodule

/* verilog/playfield_video.sv */
/*
 * playfield serializer and color select
 * 20 bits per half line, right half repeated or mirrored
 */
`timescale 1ns/10ps
`include "tia_params.svh"

module playfield_video (
	input  logic              clk,
	input  logic              rst,
	hline_if.pixel            line,
	input  logic              vblank,
	input  logic              reflect,
	input  tia_pkg::pf_bits_t pf_bits,
	input  tia_pkg::lumcol_t  colupf,
	input  tia_pkg::lumcol_t  colubk,
	output logic [3:0]        col,
	output logic [2:0]        lum
);

	localparam logic [4:0] PF_LAST = 5'(`TIA_PF_BITS - 1);

	logic [4:0] pf_idx;
	logic dir;
	logic pf_on;

	// index moves on hp2, each bit lasts one lfsr step
	always_ff @(posedge clk) begin
		if (rst) begin
			pf_idx <= '0;
			dir <= 1'b0;
		end else if (line.hp2) begin
			if (line.rhb) begin
				pf_idx <= '0;
				dir <= 1'b0;
			end else if (line.cnt) begin
				// mirror holds the last bit and walks back
				if (reflect)
					dir <= 1'b1;
				else
					pf_idx <= '0;
			end else if (dir) begin
				if (pf_idx != '0)
					pf_idx <= pf_idx - 5'd1;
			end else if (pf_idx != PF_LAST) begin
				pf_idx <= pf_idx + 5'd1;
			end
		end
	end

	assign pf_on = pf_bits[pf_idx];

	// blanked in either direction
	always_comb begin
		if (line.hblank | vblank) begin
			col = '0;
			lum = '0;
		end else if (pf_on) begin
			col = colupf.color;
			lum = colupf.luma;
		end else begin
			col = colubk.color;
			lum = colubk.luma;
		end
	end

endmodule

/* verilog/tia_video.sv */
/*
 * tia video core
 * register port, horizontal timing and playfield output
 */
`timescale 1ns/10ps
`include "tia_params.svh"

module tia_video (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   ce,
	input  logic                   cs_n,
	input  logic                   rw_n,
	input  logic [`TIA_ADDR_W-1:0] addr,
	input  logic [`TIA_DATA_W-1:0] d_in,
	output logic                   rdy,
	output logic [3:0]             col,
	output logic [2:0]             lum,
	output logic                   hsync,
	output logic                   hblank,
	output logic                   vsync,
	output logic                   vblank,
	output logic                   sync_n,
	output logic                   blk_n
);

	hline_if line ();

	logic rsync;
	logic reflect;
	tia_pkg::pf_bits_t pf_bits;
	tia_pkg::lumcol_t colupf;
	tia_pkg::lumcol_t colubk;

	//////////////////////////////////////////////////
	// timing
	//////////////////////////////////////////////////

	phase_clock_gen phase_gen (
		.clk   (clk),
		.rst   (rst),
		.ce    (ce),
		.rsync (rsync),
		.line  (line.phase)
	);

	horiz_sync_gen horiz_gen (
		.clk   (clk),
		.rst   (rst),
		.rsync (rsync),
		.line  (line.horiz),
		.hsync (hsync)
	);

	//////////////////////////////////////////////////
	// registers and pixels
	//////////////////////////////////////////////////

	tia_reg_file regs (
		.clk     (clk),
		.rst     (rst),
		.cs_n    (cs_n),
		.rw_n    (rw_n),
		.addr    (addr),
		.d_in    (d_in),
		.line    (line.regs),
		.rsync   (rsync),
		.rdy     (rdy),
		.vsync   (vsync),
		.vblank  (vblank),
		.reflect (reflect),
		.pf_bits (pf_bits),
		.colupf  (colupf),
		.colubk  (colubk)
	);

	playfield_video pixels (
		.clk     (clk),
		.rst     (rst),
		.line    (line.pixel),
		.vblank  (vblank),
		.reflect (reflect),
		.pf_bits (pf_bits),
		.colupf  (colupf),
		.colubk  (colubk),
		.col     (col),
		.lum     (lum)
	);

	assign hblank = line.hblank;

	// composite, active low
	assign sync_n = ~(hsync | vsync);
	assign blk_n = ~(line.hblank | vblank);

endmodule

/* test/tia_video_tb.sv */
/*
 * tia video testbench
 * line timing, playfield pixels, wsync, rsync and vertical levels
 */
`timescale 1ns/10ps
`include "tia_params.svh"

module tia_video_tb;

	// half line of playfield and hsync offset, in color clocks
	localparam int HALF_CC = `TIA_PF_BITS * 4;
	localparam int HSYNC_START_CC = 16;
	localparam int RSYNC_MAX_CC = 8;
	// roughly ten lines are run, two clk per color clock
	localparam int TIMEOUT_CYCLES = 12 * `TIA_CC_PER_LINE * 2 + 400;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic ce = 1'b0;
	logic cs_n = 1'b1;
	logic rw_n = 1'b1;
	logic [`TIA_ADDR_W-1:0] addr = '0;
	logic [`TIA_DATA_W-1:0] d_in = '0;
	logic rdy;
	logic [3:0] col;
	logic [2:0] lum;
	logic hsync;
	logic hblank;
	logic vsync;
	logic vblank;
	logic sync_n;
	logic blk_n;

	// register model, written by the stimulus only
	logic [7:0] m_pf0 = '0;
	logic [7:0] m_pf1 = '0;
	logic [7:0] m_pf2 = '0;
	logic [7:0] m_colupf = '0;
	logic [7:0] m_colubk = '0;
	logic m_reflect = 1'b0;
	logic m_vblank = 1'b0;

	integer seed = 70;
	int cycle_count = 0;
	int ce_count = 0;
	// rsync bookkeeping, one counter per reader
	int rsync_writes = 0;
	int rsync_cc = 0;
	int rsync_done = 0;
	int rsync_seen_pix = 0;
	// line timing monitor state
	logic hblank_q = 1'b0;
	logic hsync_q = 1'b0;
	logic have_rise = 1'b0;
	int rise_cc = 0;
	int hsync_rise_cc = 0;
	// pixel compare state
	int x = 0;
	logic tracking = 1'b0;
	logic [6:0] exp_px;
	logic hblank_prev;

	tia_video tia_video_inst (
		.clk    (clk),
		.rst    (rst),
		.ce     (ce),
		.cs_n   (cs_n),
		.rw_n   (rw_n),
		.addr   (addr),
		.d_in   (d_in),
		.rdy    (rdy),
		.col    (col),
		.lum    (lum),
		.hsync  (hsync),
		.hblank (hblank),
		.vsync  (vsync),
		.vblank (vblank),
		.sync_n (sync_n),
		.blk_n  (blk_n)
	);

	always #4 clk = ~clk;

	// one color clock every other clk
	always @(posedge clk)
		ce <= ~ce;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: no end of test after %0d clock cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// draw order pf0 4..7, pf1 7..0, pf2 0..7
	function automatic logic [19:0] build_playfield(input logic [7:0] pf0,
			input logic [7:0] pf1, input logic [7:0] pf2);
		return {pf2, pf1[0], pf1[1], pf1[2], pf1[3], pf1[4], pf1[5], pf1[6], pf1[7],
			pf0[7:4]};
	endfunction

	// {color, luma} of visible pixel x, x counted from the end of hblank
	function automatic logic [6:0] expected_pixel(input logic [19:0] pf_bits,
			input logic reflect, input logic [7:0] colupf, input logic [7:0] colubk,
			input int x);
		int pos;
		if (x < HALF_CC)
			pos = x / 4;
		else if (!reflect)
			pos = (x - HALF_CC) / 4;
		else
			pos = 19 - (x - HALF_CC) / 4;
		return pf_bits[5'(pos)] ? colupf[7:1] : colubk[7:1];
	endfunction

	// single-cycle bus write, model follows
	task automatic write_reg(input tia_pkg::write_reg_e a, input logic [7:0] d);
		@(posedge clk);
		cs_n <= 1'b0;
		rw_n <= 1'b0;
		addr <= a;
		d_in <= d;
		case (a)
			tia_pkg::VBLANK: m_vblank = d[1];
			tia_pkg::CTRLPF: m_reflect = d[0];
			tia_pkg::PF0:    m_pf0 = d;
			tia_pkg::PF1:    m_pf1 = d;
			tia_pkg::PF2:    m_pf2 = d;
			tia_pkg::COLUPF: m_colupf = d;
			tia_pkg::COLUBK: m_colubk = d;
			default: ;
		endcase
		@(posedge clk);
		cs_n <= 1'b1;
		rw_n <= 1'b1;
	endtask

	// returns at the negedge where hblank has just changed to level
	task automatic wait_hblank(input logic level);
		@(negedge clk);
		while (hblank == level)
			@(negedge clk);
		while (hblank != level)
			@(negedge clk);
	endtask

	// new playfield and colors, written inside hblank
	task automatic load_random_playfield(input logic refl);
		write_reg(tia_pkg::PF0, 8'($random(seed)));
		write_reg(tia_pkg::PF1, 8'($random(seed)));
		write_reg(tia_pkg::PF2, 8'($random(seed)));
		write_reg(tia_pkg::COLUPF, 8'($random(seed)));
		write_reg(tia_pkg::COLUBK, 8'($random(seed)));
		write_reg(tia_pkg::CTRLPF, {7'd0, refl});
	endtask

	//////////////////////////////////////////////////
	// line timing monitor
	//////////////////////////////////////////////////

	// every edge lands on an hp2 boundary, so ce counts are exact
	always @(negedge clk) begin
		if (!rst) begin
			if (ce)
				ce_count = ce_count + 1;
			if (hblank && !hblank_q) begin
				if (rsync_writes != rsync_done) begin
					check_equal("rsync_hblank_within_8_ce",
						32'((ce_count - rsync_cc) <= RSYNC_MAX_CC), 32'd1);
					rsync_done = rsync_writes;
				end else if (have_rise) begin
					check_equal("hblank_period_ce", 32'(ce_count - rise_cc),
						32'(`TIA_CC_PER_LINE));
				end
				rise_cc = ce_count;
				have_rise = 1'b1;
			end
			if (!hblank && hblank_q && have_rise)
				check_equal("hblank_width_ce", 32'(ce_count - rise_cc), 32'(`TIA_HBLANK_CC));
			// first partial line after reset has no reference
			if (hsync && !hsync_q && have_rise) begin
				check_equal("hsync_start_ce", 32'(ce_count - rise_cc), 32'(HSYNC_START_CC));
				hsync_rise_cc = ce_count;
			end
			if (!hsync && hsync_q && have_rise)
				check_equal("hsync_width_ce", 32'(ce_count - hsync_rise_cc),
					32'(`TIA_HSYNC_CC));
			hblank_q = hblank;
			hsync_q = hsync;
		end
	end

	//////////////////////////////////////////////////
	// pixel compare
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!rst && ce) begin
			if (hblank) begin
				x = 0;
				tracking = 1'b1;
				rsync_seen_pix = rsync_writes;
				check_equal("col_lum", 32'({col, lum}), 32'd0);
			end else begin
				// a line cut short by rsync is skipped
				if (tracking && rsync_writes == rsync_seen_pix) begin
					exp_px = m_vblank ? 7'd0 : expected_pixel(build_playfield(m_pf0, m_pf1,
						m_pf2), m_reflect, m_colupf, m_colubk, x);
					check_equal("col_lum", 32'({col, lum}), 32'(exp_px));
				end
				x = x + 1;
			end
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////

	initial begin
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_equal("rdy", 32'(rdy), 32'd1);
		check_equal("hsync", 32'(hsync), 32'd0);
		check_equal("hblank", 32'(hblank), 32'd0);
		check_equal("vsync", 32'(vsync), 32'd0);
		check_equal("vblank", 32'(vblank), 32'd0);

		// two straight lines, then two mirrored
		for (int n = 0; n < 4; n++) begin
			wait_hblank(1'b1);
			load_random_playfield(n >= 2);
		end

		// wsync mid line, released with the next hblank
		wait_hblank(1'b0);
		repeat (20) @(posedge clk);
		write_reg(tia_pkg::WSYNC, 8'h00);
		@(negedge clk);
		check_equal("rdy", 32'(rdy), 32'd0);
		hblank_prev = hblank;
		while (rdy == 1'b0) begin
			hblank_prev = hblank;
			@(negedge clk);
		end
		check_equal("hblank_at_rdy_rise", 32'(hblank), 32'd1);
		check_equal("hblank_before_rdy_rise", 32'(hblank_prev), 32'd0);

		// rsync mid line, monitor checks the restart and the next line
		wait_hblank(1'b0);
		repeat (40) @(posedge clk);
		rsync_cc = ce_count;
		rsync_writes = rsync_writes + 1;
		write_reg(tia_pkg::RSYNC, 8'h00);
		wait_hblank(1'b1);
		wait_hblank(1'b1);

		// one whole line under vsync and vblank
		write_reg(tia_pkg::VSYNC, 8'h02);
		write_reg(tia_pkg::VBLANK, 8'h02);
		@(negedge clk);
		check_equal("vsync", 32'(vsync), 32'd1);
		check_equal("vblank", 32'(vblank), 32'd1);
		check_equal("sync_n", 32'(sync_n), 32'd0);
		// past hblank only vblank keeps the blank active
		wait_hblank(1'b0);
		check_equal("blk_n", 32'(blk_n), 32'd0);
		check_equal("sync_n", 32'(sync_n), 32'd0);
		wait_hblank(1'b1);
		write_reg(tia_pkg::VSYNC, 8'h00);
		write_reg(tia_pkg::VBLANK, 8'h00);
		@(negedge clk);
		check_equal("vsync", 32'(vsync), 32'd0);
		check_equal("vblank", 32'(vblank), 32'd0);
		// visible again for one line
		wait_hblank(1'b0);
		check_equal("blk_n", 32'(blk_n), 32'd1);
		check_equal("sync_n", 32'(sync_n), 32'd1);
		wait_hblank(1'b1);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* src.f */
+incdir+verilog
verilog/tia_pkg.sv
verilog/hline_if.sv
verilog/phase_clock_gen.sv
verilog/horiz_sync_gen.sv
verilog/tia_reg_file.sv
verilog/playfield_video.sv
verilog/tia_video.sv
test/tia_video_tb.sv

/* run.sh */
#!/bin/sh
# build and run the tia video testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tia_video_tb \
	-f src.f -Mdir obj_dir -o tia_video_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tia_video_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
